// File: Makefile
TOP := tb_decoding_graph

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and look for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f decoding_graph.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: bench/tb_decoding_graph.sv
`include "decoding_graph_params.svh"

module tb_decoding_graph;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS   = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 300;
    // reset plus worst case for every test, rounded up to a whole microsecond
    localparam int WATCHDOG_NS =
        ((RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST) * CLK_PERIOD_NS / 1000 + 1) * 1000;
    // merge on this grid settles in far fewer cycles
    localparam int MERGE_LIMIT = 40;
    localparam int RANDOM_RUNS = 10;

    logic clk = 1'b0;
    logic rst_n_i;
    decoding_graph_pkg::stage_e stage;
    logic [`GRID_WIDTH_X-1:0] measurements;
    decoding_graph_pkg::address_t [`PU_COUNT-1:0] roots;
    logic [`PU_COUNT-1:0] boundary;
    logic [`PU_COUNT-1:0] defects;
    logic [`PU_COUNT-1:0] busy;

    int checks = 0;
    int value_errors = 0;
    int merge_timeouts = 0;
    logic [31:0] rng_state = 32'd77;

    // reference model, a union-find over fully grown edges
    int parent [`PU_COUNT];
    logic [`PU_COUNT-1:0] touches_boundary;
    logic [`PU_COUNT-1:0] cluster_boundary;
    decoding_graph_pkg::address_t exp_root [`PU_COUNT];
    logic [`PU_COUNT-1:0] exp_boundary;

    decoding_graph DUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .global_stage_i (stage),
        .measurements_i (measurements),
        .roots_o        (roots),
        .boundary_o     (boundary),
        .defects_o      (defects),
        .busy_o         (busy)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic int find_set(input int n);
        int r;
        r = n;
        while (parent[r] != r) begin
            r = parent[r];
        end
        return r;
    endfunction

    // the lower set root always survives, so a set root is its minimum
    function automatic void join_sets(input int a, input int b);
        int ra;
        int rb;
        ra = find_set(a);
        rb = find_set(b);
        if (ra < rb) begin
            parent[rb] = ra;
        end else if (rb < ra) begin
            parent[ra] = rb;
        end
    endfunction

    // growth is min(weight, cycles * defect sides), full once it hits the weight
    function automatic bit edge_full(input int sides, input int cycles);
        return (sides * cycles) >= `MAX_WEIGHT;
    endfunction

    function automatic void build_model(input logic [`PU_COUNT-1:0] pattern, input int cycles);
        int i;
        int d;
        for (int n = 0; n < `PU_COUNT; n++) begin
            parent[n] = n;
        end
        touches_boundary = '0;
        cluster_boundary = '0;
        for (int u = 0; u < `GRID_WIDTH_U; u++) begin
            for (int x = 0; x < `GRID_WIDTH_X; x++) begin
                i = u * `GRID_WIDTH_X + x;
                d = int'(pattern[i]);
                // both row ends of a round are real boundaries
                if ((x == 0 || x == `GRID_WIDTH_X - 1) && edge_full(d, cycles)) begin
                    touches_boundary[i] = 1'b1;
                end
                // and so is the edge below round 0
                if (u == 0 && edge_full(d, cycles)) begin
                    touches_boundary[i] = 1'b1;
                end
                // next row in the same round
                if (x < `GRID_WIDTH_X - 1 && edge_full(d + int'(pattern[i + 1]), cycles)) begin
                    join_sets(i, i + 1);
                end
                // same row one round up, nothing above the top round
                if (u < `GRID_WIDTH_U - 1 &&
                    edge_full(d + int'(pattern[i + `GRID_WIDTH_X]), cycles)) begin
                    join_sets(i, i + `GRID_WIDTH_X);
                end
            end
        end
        for (int n = 0; n < `PU_COUNT; n++) begin
            if (touches_boundary[n]) begin
                cluster_boundary[find_set(n)] = 1'b1;
            end
        end
        // unit index and address both count round * 4 + row
        for (int n = 0; n < `PU_COUNT; n++) begin
            exp_root[n]     = decoding_graph_pkg::address_t'(find_set(n));
            exp_boundary[n] = cluster_boundary[find_set(n)];
        end
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        checks++;
        assert (got === expected) else begin
            value_errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic load_rounds(input logic [`PU_COUNT-1:0] pattern);
        stage = decoding_graph_pkg::STAGE_MEASUREMENT_LOADING;
        // first word in sinks down to round 0
        for (int c = 0; c < `GRID_WIDTH_U; c++) begin
            measurements = pattern[c * `GRID_WIDTH_X +: `GRID_WIDTH_X];
            next_cycle();
        end
        stage = decoding_graph_pkg::STAGE_IDLE;
        measurements = '0;
    endtask

    task automatic grow_links(input int cycles);
        stage = decoding_graph_pkg::STAGE_GROW;
        repeat (cycles) next_cycle();
        stage = decoding_graph_pkg::STAGE_IDLE;
    endtask

    task automatic settle_merge();
        int waited;
        stage = decoding_graph_pkg::STAGE_MERGE;
        // busy only means something from the second merge cycle on
        next_cycle();
        next_cycle();
        waited = 2;
        while (busy != '0 && waited < MERGE_LIMIT) begin
            next_cycle();
            waited++;
        end
        assert (busy == '0) else begin
            merge_timeouts++;
            $display("merge did not settle, busy_o still %0h after %0d cycles", busy, waited);
        end
        stage = decoding_graph_pkg::STAGE_IDLE;
    endtask

    task automatic run_decode(input logic [`PU_COUNT-1:0] pattern, input int cycles);
        load_rounds(pattern);
        grow_links(cycles);
        settle_merge();
    endtask

    task automatic compare_with_model(input logic [`PU_COUNT-1:0] pattern, input int cycles,
                                      input string tag);
        build_model(pattern, cycles);
        check_value(32'(defects), 32'(pattern), {tag, " defects"});
        check_value(32'(busy), 32'd0, {tag, " busy"});
        for (int n = 0; n < `PU_COUNT; n++) begin
            check_value(32'(roots[n]), 32'(exp_root[n]), $sformatf("%s root %0d", tag, n));
            check_value(32'(boundary[n]), 32'(exp_boundary[n]),
                        $sformatf("%s boundary %0d", tag, n));
        end
    endtask

    task automatic test_reset_state();
        check_value(32'(busy), 32'd0, "busy after reset");
        check_value(32'(defects), 32'd0, "defects after reset");
        check_value(32'(boundary), 32'd0, "boundary after reset");
        for (int n = 0; n < `PU_COUNT; n++) begin
            check_value(32'(roots[n]), n, $sformatf("root %0d after reset", n));
        end
    endtask

    task automatic test_loading_order();
        // round 0 gets A, round 1 gets 3, round 2 gets 6
        load_rounds(12'h63A);
        check_value(32'(defects), 32'h63A, "defects after loading");
    endtask

    task automatic test_vertical_pair();
        // row 1 in rounds 0 and 1, one cycle fills the shared edge only
        run_decode(12'h022, 1);
        check_value(32'(roots[1]), 32'd1, "pair root of unit 1");
        check_value(32'(roots[5]), 32'd1, "pair root of unit 5");
        check_value(32'(boundary), 32'd0, "pair boundary");
        compare_with_model(12'h022, 1, "pair");
    endtask

    task automatic test_row_end_boundary();
        // unit 4 is round 1 row 0, its row-end edge fills after two cycles
        int members [4] = '{0, 4, 5, 8};
        run_decode(12'h010, 2);
        foreach (members[m]) begin
            check_value(32'(roots[members[m]]), 32'd0,
                        $sformatf("row end root of unit %0d", members[m]));
            check_value(32'(boundary[members[m]]), 32'd1,
                        $sformatf("row end boundary of unit %0d", members[m]));
        end
        compare_with_model(12'h010, 2, "row end");
    endtask

    task automatic test_top_round_virtual();
        // round 2 row 1, the edge above it must stay empty
        run_decode(12'h200, 2);
        check_value(32'(boundary), 32'd0, "top round boundary");
        check_value(32'(roots[9]), 32'd5, "top round root of unit 9");
        compare_with_model(12'h200, 2, "top round");
    endtask

    task automatic test_random_patterns();
        logic [31:0] r;
        logic [`PU_COUNT-1:0] pattern;
        int cycles;
        for (int t = 0; t < RANDOM_RUNS; t++) begin
            r = xorshift32();
            pattern = r[`PU_COUNT-1:0];
            r = xorshift32();
            cycles = 1 + int'(r % 3);
            run_decode(pattern, cycles);
            compare_with_model(pattern, cycles, $sformatf("random run %0d", t));
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        stage = decoding_graph_pkg::STAGE_IDLE;
        measurements = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        test_reset_state();
        test_loading_order();
        test_vertical_pair();
        test_row_end_boundary();
        test_top_round_virtual();
        test_random_patterns();
        $display("checks %0d, value errors %0d, merge timeouts %0d",
                 checks, value_errors, merge_timeouts);
        if (value_errors == 0 && merge_timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // last resort if a test hangs
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("checks %0d, value errors %0d, merge timeouts %0d",
                 checks, value_errors, merge_timeouts);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: decoding_graph.f
+incdir+include
logic/decoding_graph_pkg.sv
logic/neighbor_link.sv
logic/processing_unit.sv
logic/decoding_graph.sv
bench/tb_decoding_graph.sv

// File: include/decoding_graph_params.svh
`ifndef DECODING_GRAPH_PARAMS_SVH
`define DECODING_GRAPH_PARAMS_SVH

// stabilizer rows in one measurement round
`define GRID_WIDTH_X 4

// measurement rounds held in the graph at once
`define GRID_WIDTH_U 3

// growth a link needs before it counts as fully grown
`define MAX_WEIGHT 2

// address fields, round in the upper bits and row in the lower bits
`define X_BIT_WIDTH ($clog2(`GRID_WIDTH_X))
`define U_BIT_WIDTH ($clog2(`GRID_WIDTH_U))
`define ADDRESS_WIDTH (`X_BIT_WIDTH + `U_BIT_WIDTH)

// one unit per row and round
`define PU_COUNT (`GRID_WIDTH_X * `GRID_WIDTH_U)

// counter wide enough to hold MAX_WEIGHT
`define LINK_BIT_WIDTH ($clog2(`MAX_WEIGHT + 1))

// north, south, down and up
`define NEIGHBOR_COUNT 4

`endif

// File: logic/decoding_graph.sv
`include "decoding_graph_params.svh"

module decoding_graph (
    input  logic                                                clk,
    input  logic                                                rst_n_i,
    input  decoding_graph_pkg::stage_e                          global_stage_i,
    input  logic [`GRID_WIDTH_X-1:0]                            measurements_i,
    output wire decoding_graph_pkg::address_t [`PU_COUNT-1:0]   roots_o,
    output wire [`PU_COUNT-1:0]                                 boundary_o,
    output wire [`PU_COUNT-1:0]                                 defects_o,
    output wire [`PU_COUNT-1:0]                                 busy_o
);

    // growth request of each unit, indexed like the outputs
    wire [`PU_COUNT-1:0] pu_increase;

    // gated neighbor data, one slot per direction, written by the links
    wire decoding_graph_pkg::address_t [`NEIGHBOR_COUNT-1:0] nb_root [`PU_COUNT];
    wire [`NEIGHBOR_COUNT-1:0] nb_boundary [`PU_COUNT];

    genvar u;
    genvar x;
    genvar e;
    genvar k;

    // unit array
    for (u = 0; u < `GRID_WIDTH_U; u++) begin : g_round
        for (x = 0; x < `GRID_WIDTH_X; x++) begin : g_row
            localparam int IDX = u * `GRID_WIDTH_X + x;
            // round in the upper field, row in the lower
            localparam decoding_graph_pkg::address_t ADDR =
                decoding_graph_pkg::address_t'((u << `X_BIT_WIDTH) + x);

            wire meas_in;

            // top round takes the fresh word, lower rounds take the round above
            if (u == `GRID_WIDTH_U - 1) begin : g_top
                assign meas_in = measurements_i[x];
            end else begin : g_shift
                assign meas_in = defects_o[IDX + `GRID_WIDTH_X];
            end

            processing_unit #(
                .ADDRESS(ADDR)
            ) u_pu (
                .clk                 (clk),
                .rst_n_i             (rst_n_i),
                .global_stage_i      (global_stage_i),
                .measurement_i       (meas_in),
                .measurement_o       (defects_o[IDX]),
                .neighbor_root_i     (nb_root[IDX]),
                .neighbor_boundary_i (nb_boundary[IDX]),
                .increase_o          (pu_increase[IDX]),
                .root_o              (roots_o[IDX]),
                .boundary_o          (boundary_o[IDX]),
                .busy_o              (busy_o[IDX])
            );
        end
    end

    // north/south links inside each round
    // edge e sits between row e-1 and row e, edges 0 and GRID_WIDTH_X are row ends
    for (u = 0; u < `GRID_WIDTH_U; u++) begin : g_ns_round
        for (e = 0; e <= `GRID_WIDTH_X; e++) begin : g_ns_edge
            localparam bit LOW_END  = (e == 0);
            localparam bit HIGH_END = (e == `GRID_WIDTH_X);
            localparam bit HAS_B    = !LOW_END && !HIGH_END;
            localparam decoding_graph_pkg::link_kind_e KIND = HAS_B ?
                decoding_graph_pkg::LINK_INTERNAL : decoding_graph_pkg::LINK_BOUNDARY;
            // side a is the row above the edge, or row 0 at the low end
            localparam int A_IDX = u * `GRID_WIDTH_X + (LOW_END ? 0 : e - 1);
            localparam decoding_graph_pkg::neighbor_dir_e A_DIR = LOW_END ?
                decoding_graph_pkg::DIR_NORTH : decoding_graph_pkg::DIR_SOUTH;
            // no b side at the ends, point at side a so the index stays legal
            localparam int B_IDX = HAS_B ? u * `GRID_WIDTH_X + e : A_IDX;

            wire decoding_graph_pkg::address_t b_root;
            wire b_boundary;

            neighbor_link #(
                .LINK_KIND(KIND)
            ) u_link (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .global_stage_i (global_stage_i),
                .a_increase_i   (pu_increase[A_IDX]),
                .b_increase_i   (HAS_B ? pu_increase[B_IDX] : 1'b0),
                .a_root_i       (roots_o[A_IDX]),
                .b_root_i       (HAS_B ? roots_o[B_IDX] : decoding_graph_pkg::NO_ROOT),
                .a_boundary_i   (boundary_o[A_IDX]),
                .b_boundary_i   (HAS_B ? boundary_o[B_IDX] : 1'b0),
                .a_root_o       (nb_root[A_IDX][A_DIR]),
                .b_root_o       (b_root),
                .a_boundary_o   (nb_boundary[A_IDX][A_DIR]),
                .b_boundary_o   (b_boundary)
            );

            if (HAS_B) begin : g_b_side
                assign nb_root[B_IDX][decoding_graph_pkg::DIR_NORTH]     = b_root;
                assign nb_boundary[B_IDX][decoding_graph_pkg::DIR_NORTH] = b_boundary;
            end
        end
    end

    // up/down links between rounds
    // level k sits under round k, level GRID_WIDTH_U is above the top round
    for (k = 0; k <= `GRID_WIDTH_U; k++) begin : g_ud_level
        for (x = 0; x < `GRID_WIDTH_X; x++) begin : g_ud_row
            localparam bit BOTTOM = (k == 0);
            localparam bit TOP    = (k == `GRID_WIDTH_U);
            localparam bit HAS_B  = !BOTTOM && !TOP;
            // real boundary below round 0, virtual edge above the top round
            localparam decoding_graph_pkg::link_kind_e KIND =
                BOTTOM ? decoding_graph_pkg::LINK_BOUNDARY :
                TOP    ? decoding_graph_pkg::LINK_VIRTUAL  :
                         decoding_graph_pkg::LINK_INTERNAL;
            // side a is the round under the level, or round 0 at the bottom
            localparam int A_IDX = (BOTTOM ? 0 : k - 1) * `GRID_WIDTH_X + x;
            localparam decoding_graph_pkg::neighbor_dir_e A_DIR = BOTTOM ?
                decoding_graph_pkg::DIR_DOWN : decoding_graph_pkg::DIR_UP;
            localparam int B_IDX = HAS_B ? k * `GRID_WIDTH_X + x : A_IDX;

            wire decoding_graph_pkg::address_t b_root;
            wire b_boundary;

            neighbor_link #(
                .LINK_KIND(KIND)
            ) u_link (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .global_stage_i (global_stage_i),
                .a_increase_i   (pu_increase[A_IDX]),
                .b_increase_i   (HAS_B ? pu_increase[B_IDX] : 1'b0),
                .a_root_i       (roots_o[A_IDX]),
                .b_root_i       (HAS_B ? roots_o[B_IDX] : decoding_graph_pkg::NO_ROOT),
                .a_boundary_i   (boundary_o[A_IDX]),
                .b_boundary_i   (HAS_B ? boundary_o[B_IDX] : 1'b0),
                .a_root_o       (nb_root[A_IDX][A_DIR]),
                .b_root_o       (b_root),
                .a_boundary_o   (nb_boundary[A_IDX][A_DIR]),
                .b_boundary_o   (b_boundary)
            );

            if (HAS_B) begin : g_b_side
                assign nb_root[B_IDX][decoding_graph_pkg::DIR_DOWN]     = b_root;
                assign nb_boundary[B_IDX][decoding_graph_pkg::DIR_DOWN] = b_boundary;
            end
        end
    end

endmodule

// File: logic/decoding_graph_pkg.sv
`include "decoding_graph_params.svh"

package decoding_graph_pkg;

    // stage code driven by the outside controller
    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3,
        STAGE_RESULT_VALID        = 3'd4
    } stage_e;

    // round * GRID_WIDTH_X + row, so lower rounds win the min-root race
    typedef logic [`ADDRESS_WIDTH-1:0] address_t;

    // all ones never wins a min compare against a real unit
    localparam address_t NO_ROOT = '1;

    // slot of a neighbor in the per-unit neighbor vectors
    typedef enum logic [1:0] {
        DIR_NORTH = 2'd0,
        DIR_SOUTH = 2'd1,
        DIR_DOWN  = 2'd2,
        DIR_UP    = 2'd3
    } neighbor_dir_e;

    // internal links join two units
    // boundary links have a unit on side a only
    // virtual links close the top round and never grow
    typedef enum logic [1:0] {
        LINK_INTERNAL = 2'd0,
        LINK_BOUNDARY = 2'd1,
        LINK_VIRTUAL  = 2'd2
    } link_kind_e;

endpackage

// File: logic/neighbor_link.sv
`include "decoding_graph_params.svh"

module neighbor_link #(
    parameter decoding_graph_pkg::link_kind_e LINK_KIND = decoding_graph_pkg::LINK_INTERNAL
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  decoding_graph_pkg::stage_e      global_stage_i,
    input  logic                            a_increase_i,
    input  logic                            b_increase_i,
    input  decoding_graph_pkg::address_t    a_root_i,
    input  decoding_graph_pkg::address_t    b_root_i,
    input  logic                            a_boundary_i,
    input  logic                            b_boundary_i,
    output decoding_graph_pkg::address_t    a_root_o,
    output decoding_graph_pkg::address_t    b_root_o,
    output logic                            a_boundary_o,
    output logic                            b_boundary_o
);

    localparam int unsigned GROWTH_WIDTH = `LINK_BIT_WIDTH;
    // one spare bit so both sides growing at once cannot wrap
    localparam int unsigned SUM_WIDTH = GROWTH_WIDTH + 1;
    localparam logic [GROWTH_WIDTH-1:0] FULL_WEIGHT = GROWTH_WIDTH'(`MAX_WEIGHT);

    logic [GROWTH_WIDTH-1:0] growth_q;
    logic [SUM_WIDTH-1:0] step;
    logic [SUM_WIDTH-1:0] growth_sum;
    logic fully_grown;

    // each side with a defect adds one per grow cycle
    always_comb begin
        step = '0;
        if (LINK_KIND != decoding_graph_pkg::LINK_VIRTUAL) begin
            step = SUM_WIDTH'(a_increase_i);
            if (LINK_KIND == decoding_graph_pkg::LINK_INTERNAL) begin
                step = step + SUM_WIDTH'(b_increase_i);
            end
        end
        growth_sum = SUM_WIDTH'(growth_q) + step;
        // saturate at the edge weight
        if (growth_sum > SUM_WIDTH'(FULL_WEIGHT)) begin
            growth_sum = SUM_WIDTH'(FULL_WEIGHT);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            growth_q <= '0;
        end else if (global_stage_i == decoding_graph_pkg::STAGE_MEASUREMENT_LOADING) begin
            growth_q <= '0;
        end else if (global_stage_i == decoding_graph_pkg::STAGE_GROW) begin
            growth_q <= growth_sum[GROWTH_WIDTH-1:0];
        end
    end

    assign fully_grown = (growth_q == FULL_WEIGHT);

    // nothing crosses until the edge is full
    always_comb begin
        a_root_o     = decoding_graph_pkg::NO_ROOT;
        b_root_o     = decoding_graph_pkg::NO_ROOT;
        a_boundary_o = 1'b0;
        b_boundary_o = 1'b0;
        if (fully_grown) begin
            if (LINK_KIND == decoding_graph_pkg::LINK_BOUNDARY) begin
                // boundary offers no root, only the flag
                a_boundary_o = 1'b1;
            end else begin
                a_root_o     = b_root_i;
                a_boundary_o = b_boundary_i;
                b_root_o     = a_root_i;
                b_boundary_o = a_boundary_i;
            end
        end
    end

endmodule

// File: logic/processing_unit.sv
`include "decoding_graph_params.svh"

module processing_unit #(
    parameter decoding_graph_pkg::address_t ADDRESS = '0
) (
    input  logic                                                clk,
    input  logic                                                rst_n_i,
    input  decoding_graph_pkg::stage_e                          global_stage_i,
    input  logic                                                measurement_i,
    output logic                                                measurement_o,
    input  decoding_graph_pkg::address_t [`NEIGHBOR_COUNT-1:0]  neighbor_root_i,
    input  logic [`NEIGHBOR_COUNT-1:0]                          neighbor_boundary_i,
    output logic                                                increase_o,
    output decoding_graph_pkg::address_t                        root_o,
    output logic                                                boundary_o,
    output logic                                                busy_o
);

    // syndrome bit of this stabilizer in this round
    logic defect_q;

    // merge candidates for the next cycle
    decoding_graph_pkg::address_t min_root;
    logic merged_boundary;

    // lowest address offered by any grown link, links that are not grown offer all ones
    always_comb begin
        min_root = root_o;
        for (int n = 0; n < `NEIGHBOR_COUNT; n++) begin
            if (neighbor_root_i[n] < min_root) begin
                min_root = neighbor_root_i[n];
            end
        end
        // a boundary anywhere in the cluster spreads to every member
        merged_boundary = boundary_o | (|neighbor_boundary_i);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            defect_q   <= 1'b0;
            root_o     <= ADDRESS;
            boundary_o <= 1'b0;
            busy_o     <= 1'b0;
        end else begin
            case (global_stage_i)
                decoding_graph_pkg::STAGE_MEASUREMENT_LOADING: begin
                    // shift one round down, every unit starts as its own cluster
                    defect_q   <= measurement_i;
                    root_o     <= ADDRESS;
                    boundary_o <= 1'b0;
                    busy_o     <= 1'b0;
                end
                decoding_graph_pkg::STAGE_MERGE: begin
                    root_o     <= min_root;
                    boundary_o <= merged_boundary;
                    // any change may still ripple to the neighbors next cycle
                    busy_o     <= (min_root != root_o) || (merged_boundary != boundary_o);
                end
                default: begin
                    busy_o <= 1'b0;
                end
            endcase
        end
    end

    // defect moves on to the round below during loading
    assign measurement_o = defect_q;

    // links only count this while the stage is grow
    assign increase_o = defect_q;

endmodule
